/* compile.f */
+incdir+include
hdl/crypto_pkg.sv
hdl/frame_pkg.sv
hdl/frame_disassembler.sv
hdl/core_input_arbiter.sv
hdl/keystream_cipher.sv
hdl/frame_reassembler.sv
hdl/encr_datapath.sv
verification/tb_encr_datapath.sv

/* hdl/core_input_arbiter.sv */
// Cipher core input arbiter
// Picks the frame beat or a single-cycle request word

`timescale 1ns/1ps

module core_input_arbiter
(
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  frame_pkg::core_beat_t  i_frame_beat,
    input  logic                   i_frame_idle,
    input  logic                   i_boot_up,
    input  crypto_pkg::data_word_t i_sc_data,
    input  logic                   i_sc_valid,
    output frame_pkg::core_beat_t  o_core_beat
);
    import frame_pkg::*;

    logic       sc_grant;
    core_beat_t sc_beat;
    core_beat_t beat_next;

    // Boot-up or an idle frame path hands the core to the requester
    assign sc_grant = i_boot_up | i_frame_idle;

    // Single-cycle words always run with counter 1
    always_comb
    begin
        sc_beat.data       = i_sc_data;
        sc_beat.valid      = i_sc_valid;
        sc_beat.sof        = 1'b0;
        sc_beat.payload    = 1'b1;
        sc_beat.last       = 1'b0;
        sc_beat.from_frame = 1'b0;
        sc_beat.index      = SC_WORD_INDEX;
    end

    assign beat_next = sc_grant ? sc_beat : i_frame_beat;  // Loser gets no beat

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_core_beat.valid <= 1'b0;
        else
            o_core_beat <= beat_next;
    end

endmodule

/* hdl/crypto_pkg.sv */
// Cipher word widths and constants
// Cipher mode encoding
// Key, IV, tag and tagged result types

package crypto_pkg;

    // ************************************************************************
    // Widths
    // ************************************************************************
    localparam int DATA_BITS    = 64;
    localparam int IV_BITS      = 48;
    localparam int COUNTER_BITS = 16;  // IV and counter fill one word

    // ************************************************************************
    // Types
    // ************************************************************************
    typedef logic [DATA_BITS-1:0] data_word_t;
    typedef logic [DATA_BITS-1:0] key_t;
    typedef logic [IV_BITS-1:0]   iv_t;
    typedef logic [DATA_BITS-1:0] tag_t;

    // Mode register encoding
    typedef enum logic [1:0]
    {
        MODE_BYPASS    = 2'd0,
        MODE_ENCRYPT   = 2'd1,
        MODE_DECRYPT   = 2'd2,
        MODE_AUTH_ONLY = 2'd3
    } cipher_mode_e;

    typedef struct packed
    {
        tag_t tag;
        logic valid;  // One-cycle strobe
    } tagged_t;

endpackage

/* hdl/encr_datapath.sv */
// Frame encryption datapath top level
// Disassembler, core arbiter, keystream cipher and reassembler

`timescale 1ns/1ps

module encr_datapath
(
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  frame_pkg::data_beat_t    i_beat,
    input  crypto_pkg::cipher_mode_e i_mode,
    input  crypto_pkg::key_t         i_key,
    input  crypto_pkg::iv_t          i_iv,
    input  logic                     i_boot_up,
    input  crypto_pkg::data_word_t   i_sc_data,
    input  logic                     i_sc_valid,
    output frame_pkg::data_beat_t    o_beat,
    output crypto_pkg::tagged_t      o_tag,
    output crypto_pkg::data_word_t   o_sc_data,
    output logic                     o_sc_valid
);
    import crypto_pkg::*;
    import frame_pkg::*;

    core_beat_t frame_beat;   // Disassembler to arbiter
    logic       frame_idle;
    core_beat_t core_beat;    // Arbiter to cipher
    core_beat_t cipher_beat;  // Cipher to reassembler
    tagged_t    cipher_tag;

    frame_disassembler u_frame_disassembler
    (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_beat  (i_beat),
        .o_beat  (frame_beat),
        .o_idle  (frame_idle)
    );

    core_input_arbiter u_core_input_arbiter
    (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_frame_beat (frame_beat),
        .i_frame_idle (frame_idle),
        .i_boot_up    (i_boot_up),
        .i_sc_data    (i_sc_data),
        .i_sc_valid   (i_sc_valid),
        .o_core_beat  (core_beat)
    );

    keystream_cipher u_keystream_cipher
    (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_beat     (core_beat),
        .i_mode     (i_mode),
        .i_key      (i_key),
        .i_iv       (i_iv),
        .o_beat     (cipher_beat),
        .o_tag      (cipher_tag),
        .o_sc_data  (o_sc_data),
        .o_sc_valid (o_sc_valid)
    );

    frame_reassembler u_frame_reassembler
    (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_beat  (cipher_beat),
        .i_tag   (cipher_tag),
        .o_beat  (o_beat),
        .o_tag   (o_tag)
    );

endmodule

/* hdl/frame_disassembler.sv */
// Frame disassembler
// Numbers the words of each frame and flags overhead, payload and last word
// Reports when the frame path is idle

`timescale 1ns/1ps

module frame_disassembler
(
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  frame_pkg::data_beat_t i_beat,
    output frame_pkg::core_beat_t o_beat,
    output logic                  o_idle
);
    import frame_pkg::*;

    logic                  in_frame;    // Between sof and last word
    logic [INDEX_BITS-1:0] next_index;  // Index given to the next word
    logic                  take_sof;
    logic                  take_word;
    core_beat_t            beat_next;

    // A sof starts a new frame even mid-frame
    assign take_sof  = i_beat.valid & i_beat.sof;
    assign take_word = i_beat.valid & ~i_beat.sof & in_frame;  // Stray words dropped

    always_comb
    begin
        beat_next.data       = i_beat.data;
        beat_next.valid      = take_sof | take_word;
        beat_next.sof        = take_sof;
        beat_next.payload    = ~take_sof;  // Word 0 is overhead
        beat_next.last       = take_word & (next_index == LAST_INDEX);
        beat_next.from_frame = 1'b1;
        beat_next.index      = take_sof ? '0 : next_index;
    end

    // Word index counter
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            in_frame   <= 1'b0;
            next_index <= '0;
        end
        else if (take_sof)
        begin
            in_frame   <= 1'b1;
            next_index <= INDEX_BITS'(1);
        end
        else if (take_word)
        begin
            if (next_index == LAST_INDEX)
                in_frame <= 1'b0;  // Counter stops here
            else
                next_index <= next_index + 1'b1;
        end
    end

    // Output stage and idle flag
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_beat.valid <= 1'b0;
            o_idle       <= 1'b1;
        end
        else
        begin
            o_beat <= beat_next;
            if (take_sof)
                o_idle <= 1'b0;
            else if (o_beat.valid & o_beat.last)
                o_idle <= 1'b1;  // Last word has left this stage
        end
    end

endmodule

/* hdl/frame_pkg.sv */
// Frame layout constants
// Data beat at the datapath boundary
// Core beat carried between disassembler, arbiter, cipher and reassembler

package frame_pkg;

    // ************************************************************************
    // Frame layout
    // ************************************************************************
    localparam int FRAME_WORDS = 8;  // Overhead word plus seven payload words
    localparam int INDEX_BITS  = 3;

    localparam logic [INDEX_BITS-1:0] LAST_INDEX    = INDEX_BITS'(FRAME_WORDS - 1);
    localparam logic [INDEX_BITS-1:0] SC_WORD_INDEX = INDEX_BITS'(1);  // Counter 1

    // ************************************************************************
    // Beats
    // ************************************************************************
    typedef struct packed
    {
        crypto_pkg::data_word_t data;
        logic                   valid;
        logic                   sof;
    } data_beat_t;

    typedef struct packed
    {
        crypto_pkg::data_word_t data;
        logic                   valid;
        logic                   sof;
        logic                   payload;     // Goes through the keystream
        logic                   last;        // Word index 7
        logic                   from_frame;  // Clear for single-cycle words
        logic [INDEX_BITS-1:0]  index;
    } core_beat_t;

endpackage

/* hdl/frame_reassembler.sv */
// Frame reassembler
// Rebuilds the output frame stream from cipher beats
// Lines the tag up with the last output word

`timescale 1ns/1ps

module frame_reassembler
(
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  frame_pkg::core_beat_t i_beat,
    input  crypto_pkg::tagged_t   i_tag,
    output frame_pkg::data_beat_t o_beat,
    output crypto_pkg::tagged_t   o_tag
);

    logic frame_open;  // Sof seen, last word not yet
    logic take_beat;
    logic take_tag;

    assign take_beat = i_beat.valid & i_beat.from_frame;

    // Tag only closes a frame that was opened by its own sof
    assign take_tag = take_beat & i_beat.last & i_tag.valid & frame_open;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            frame_open <= 1'b0;
        else if (take_beat & i_beat.sof)
            frame_open <= 1'b1;
        else if (take_beat & i_beat.last)
            frame_open <= 1'b0;
    end

    // ************************************************************************
    // Output stage
    // ************************************************************************
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_beat.valid <= 1'b0;
            o_tag.valid  <= 1'b0;
        end
        else
        begin
            o_beat.data  <= i_beat.data;
            o_beat.sof   <= i_beat.sof;
            o_beat.valid <= take_beat;
            o_tag.valid  <= take_tag;
            if (take_tag)
                o_tag.tag <= i_tag.tag;  // Held until the next frame closes
        end
    end

endmodule

/* hdl/keystream_cipher.sv */
// Keystream cipher stage
// Applies the keystream according to the mode and accumulates the frame tag
// Returns single-cycle results on their own outputs

`timescale 1ns/1ps

module keystream_cipher
(
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  frame_pkg::core_beat_t    i_beat,
    input  crypto_pkg::cipher_mode_e i_mode,
    input  crypto_pkg::key_t         i_key,
    input  crypto_pkg::iv_t          i_iv,
    output frame_pkg::core_beat_t    o_beat,
    output crypto_pkg::tagged_t      o_tag,
    output crypto_pkg::data_word_t   o_sc_data,
    output logic                     o_sc_valid
);
    import crypto_pkg::*;
    import frame_pkg::*;

    logic [COUNTER_BITS-1:0] counter;
    data_word_t              keystream;
    data_word_t              result;
    data_word_t              cipher_text;
    tag_t                    tag_acc;
    logic                    frame_beat;
    logic                    sc_beat;
    logic                    apply_xor;
    logic                    tag_on;
    core_beat_t              beat_out;
    data_word_t              sc_data_q;
    logic                    sc_valid_q;

    // ************************************************************************
    // Keystream and data path
    // ************************************************************************
    assign counter    = COUNTER_BITS'(i_beat.index);  // Word index is the counter
    assign keystream  = i_key ^ {i_iv, counter};
    assign frame_beat = i_beat.valid & i_beat.from_frame;
    assign sc_beat    = i_beat.valid & ~i_beat.from_frame;

    // Single-cycle words are always ciphered
    assign apply_xor = ~i_beat.from_frame |
                       (i_beat.payload & ((i_mode == MODE_ENCRYPT) | (i_mode == MODE_DECRYPT)));
    assign result      = apply_xor ? (i_beat.data ^ keystream) : i_beat.data;
    assign cipher_text = (i_mode == MODE_ENCRYPT) ? result : i_beat.data;
    assign tag_on      = frame_beat & (i_mode != MODE_BYPASS);

    always_comb
    begin
        beat_out       = i_beat;
        beat_out.data  = result;
        beat_out.valid = frame_beat;
    end

    // ************************************************************************
    // Tag accumulator
    // ************************************************************************
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            tag_acc     <= '0;
            o_tag.valid <= 1'b0;
        end
        else
        begin
            o_tag.valid <= tag_on & i_beat.last;
            if (frame_beat & i_beat.sof)
                tag_acc <= '0;  // Old sums dropped on a new frame
            else if (tag_on & i_beat.payload)
                tag_acc <= tag_acc ^ cipher_text;
            if (tag_on & i_beat.last)
                o_tag.tag <= i_key ^ tag_acc ^ cipher_text;  // Fold in key
        end
    end

    // Frame output and two-stage single-cycle return
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_beat.valid <= 1'b0;
            sc_valid_q   <= 1'b0;
            o_sc_valid   <= 1'b0;
        end
        else
        begin
            o_beat     <= beat_out;
            sc_valid_q <= sc_beat;
            sc_data_q  <= result;
            o_sc_valid <= sc_valid_q;
            o_sc_data  <= sc_data_q;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing -f compile.f --top-module tb_encr_datapath &&
./obj_dir/Vtb_encr_datapath | tee /dev/stderr | grep -q "All tests passed" &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }

/* include/tb_checks.svh */
// Reference models for the keystream and the frame tag
// Compare tasks for output beats, tags, single-cycle words and output cycles

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Key XOR the IV followed by the 16-bit counter
function automatic data_word_t keystream_model(input key_t key, input iv_t iv, input int n);
    return key ^ {iv, COUNTER_BITS'(n)};
endfunction

// Key XOR all seven ciphertext words without the overhead word
function automatic tag_t tag_model(input key_t key, input data_word_t words [FRAME_WORDS]);
    tag_t acc;
    acc = key;
    for (int i = 1; i < FRAME_WORDS; i++)
        acc = acc ^ words[i];
    return acc;
endfunction

task automatic compare_beat(input string name, input data_beat_t exp, input data_beat_t act);
    if (act !== exp)
    begin
        value_errors++;
        $display("ERROR %s: expected data %h sof %b, actual data %h sof %b",
                 name, exp.data, exp.sof, act.data, act.sof);
    end
endtask

task automatic compare_tag(input string name, input tag_t exp, input tag_t act);
    if (act !== exp)
    begin
        value_errors++;
        $display("ERROR %s: expected tag %h, actual tag %h", name, exp, act);
    end
endtask

task automatic compare_word(input string name, input data_word_t exp, input data_word_t act);
    if (act !== exp)
    begin
        value_errors++;
        $display("ERROR %s: expected word %h, actual word %h", name, exp, act);
    end
endtask

// Edge at which an output was produced
task automatic compare_cycle(input string name, input int exp, input int act);
    if (act != exp)
    begin
        value_errors++;
        $display("ERROR %s: expected output at cycle %0d, actual cycle %0d", name, exp, act);
    end
endtask

`endif

/* verification/tb_encr_datapath.sv */
// Testbench for the frame encryption datapath
// Clock, reset, output monitor, timeout and the directed tests

`timescale 1ns/1ps

module tb_encr_datapath;
    import crypto_pkg::*;
    import frame_pkg::*;

    localparam int FRAME_LATENCY  = 4;
    localparam int SC_LATENCY     = 3;
    localparam int SETTLE_CYCLES  = 6;     // Quiet time for checks that expect nothing
    localparam int TIMEOUT_CYCLES = 2000;  // Tests need about 400 cycles

    logic         clock = 1'b0;
    logic         reset;
    data_beat_t   beat_in;
    cipher_mode_e mode;
    key_t         key;
    iv_t          iv;
    logic         boot_up;
    data_word_t   sc_data;
    logic         sc_valid;
    data_beat_t   beat_out;
    tagged_t      tag_out;
    data_word_t   sc_data_out;
    logic         sc_valid_out;

    int cycle        = 0;
    int value_errors = 0;
    int other_errors = 0;

    // Observed outputs with the edge that produced them
    data_beat_t beat_q [$];
    int         beat_cyc_q [$];
    tag_t       tag_q [$];
    int         tag_cyc_q [$];
    data_word_t sc_q [$];
    int         sc_cyc_q [$];

    data_word_t frame_words [FRAME_WORDS];  // Words sent
    data_word_t exp_words [FRAME_WORDS];
    data_word_t out_words [FRAME_WORDS];    // Words received
    int         drive_cycle [FRAME_WORDS];
    int         last_cycle;

    `include "tb_checks.svh"

    encr_datapath i_encr_datapath
    (
        .i_clock    (clock),
        .i_reset    (reset),
        .i_beat     (beat_in),
        .i_mode     (mode),
        .i_key      (key),
        .i_iv       (iv),
        .i_boot_up  (boot_up),
        .i_sc_data  (sc_data),
        .i_sc_valid (sc_valid),
        .o_beat     (beat_out),
        .o_tag      (tag_out),
        .o_sc_data  (sc_data_out),
        .o_sc_valid (sc_valid_out)
    );

    always #10 clock = ~clock;

    // ************************************************************************
    // Output monitor
    // ************************************************************************
    // Values seen here were registered one edge earlier
    always @(posedge clock)
    begin
        cycle <= cycle + 1;
        if (beat_out.valid)
        begin
            beat_q.push_back(beat_out);
            beat_cyc_q.push_back(cycle - 1);
        end
        if (tag_out.valid)
        begin
            tag_q.push_back(tag_out.tag);
            tag_cyc_q.push_back(cycle - 1);
        end
        if (sc_valid_out)
        begin
            sc_q.push_back(sc_data_out);
            sc_cyc_q.push_back(cycle - 1);
        end
    end

    initial
    begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    // ************************************************************************
    // Frame helpers
    // ************************************************************************
    task automatic new_frame();
        for (int i = 0; i < FRAME_WORDS; i++)
            frame_words[i] = {$urandom, $urandom};
    endtask

    // Payload XORed with the keystream in encrypt and decrypt
    task automatic build_expected(input cipher_mode_e m);
        for (int i = 0; i < FRAME_WORDS; i++)
            if (i > 0 && (m == MODE_ENCRYPT || m == MODE_DECRYPT))
                exp_words[i] = frame_words[i] ^ keystream_model(key, iv, i);
            else
                exp_words[i] = frame_words[i];
    endtask

    task automatic send_frame(input int n_words, input int max_gap);
        int gap;
        for (int i = 0; i < n_words; i++)
        begin
            @(posedge clock);
            beat_in.data  <= frame_words[i];
            beat_in.valid <= 1'b1;
            beat_in.sof   <= (i == 0);
            drive_cycle[i] = cycle;
            gap = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
            repeat (gap)
            begin
                @(posedge clock);
                beat_in.valid <= 1'b0;  // Idle word between beats
            end
        end
        @(posedge clock);
        beat_in.valid <= 1'b0;
    endtask

    task automatic collect_frame(input string name, input int n_words);
        data_beat_t want;
        data_beat_t got;
        for (int i = 0; i < n_words; i++)
        begin
            while (beat_q.size() == 0)
                @(posedge clock);
            got = beat_q.pop_front();
            want.data  = exp_words[i];
            want.valid = 1'b1;
            want.sof   = (i == 0);
            compare_beat(name, want, got);
            last_cycle = beat_cyc_q.pop_front();
            compare_cycle(name, drive_cycle[i] + FRAME_LATENCY, last_cycle);
            out_words[i] = got.data;
        end
    endtask

    // Tag must come out together with the last word
    task automatic check_tag(input string name, input tag_t expected);
        if (tag_q.size() == 0)
        begin
            other_errors++;
            $display("%s: no tag came out with the last word of the frame", name);
        end
        else
        begin
            compare_tag(name, expected, tag_q.pop_front());
            compare_cycle(name, last_cycle, tag_cyc_q.pop_front());
        end
    endtask

    task automatic expect_no_tag(input string name);
        repeat (SETTLE_CYCLES) @(posedge clock);
        if (tag_q.size() != 0)
        begin
            other_errors++;
            $display("%s: a tag came out for a frame that should have none", name);
            tag_q.delete();
            tag_cyc_q.delete();
        end
    endtask

    // ************************************************************************
    // Directed tests
    // ************************************************************************
    task automatic bypass_passes_through();
        @(posedge clock);
        mode <= MODE_BYPASS;
        new_frame();
        build_expected(MODE_BYPASS);
        send_frame(FRAME_WORDS, 1);
        collect_frame("bypass", FRAME_WORDS);
        expect_no_tag("bypass");
    endtask

    task automatic encrypt_then_decrypt();
        data_word_t plain [FRAME_WORDS];
        tag_t       enc_tag;
        @(posedge clock);
        mode <= MODE_ENCRYPT;
        new_frame();
        plain = frame_words;
        build_expected(MODE_ENCRYPT);
        send_frame(FRAME_WORDS, 2);
        collect_frame("encrypt", FRAME_WORDS);
        enc_tag = tag_model(key, exp_words);  // Over the output ciphertext
        check_tag("encrypt", enc_tag);
        @(posedge clock);
        mode <= MODE_DECRYPT;
        frame_words = out_words;  // Feed the ciphertext back in
        exp_words   = plain;
        send_frame(FRAME_WORDS, 2);
        collect_frame("decrypt", FRAME_WORDS);
        check_tag("decrypt", enc_tag);
    endtask

    task automatic auth_only_tags_frame();
        @(posedge clock);
        mode <= MODE_AUTH_ONLY;
        new_frame();
        build_expected(MODE_AUTH_ONLY);
        send_frame(FRAME_WORDS, 1);
        collect_frame("auth_only", FRAME_WORDS);
        check_tag("auth_only", tag_model(key, frame_words));
    endtask

    task automatic resync_drops_old_frame();
        @(posedge clock);
        mode <= MODE_ENCRYPT;
        new_frame();
        build_expected(MODE_ENCRYPT);
        send_frame(4, 0);  // Cut short after word 3
        collect_frame("resync_abort", 4);
        expect_no_tag("resync_abort");
        new_frame();
        build_expected(MODE_ENCRYPT);
        send_frame(FRAME_WORDS, 1);
        collect_frame("resync", FRAME_WORDS);
        check_tag("resync", tag_model(key, exp_words));
    endtask

    // Frame path held busy so that only boot-up can grant the request
    task automatic single_cycle_during_boot();
        data_word_t word;
        int         sent;
        @(posedge clock);
        mode <= MODE_BYPASS;
        new_frame();
        build_expected(MODE_BYPASS);
        send_frame(2, 0);  // Frame left open after word 1
        collect_frame("sc_boot_open", 2);
        word = {$urandom, $urandom};
        @(posedge clock);
        boot_up  <= 1'b1;
        sc_data  <= word;
        sc_valid <= 1'b1;
        sent = cycle;
        @(posedge clock);
        sc_valid <= 1'b0;
        while (sc_q.size() == 0)
            @(posedge clock);
        compare_word("sc_boot", word ^ keystream_model(key, iv, 1), sc_q.pop_front());
        compare_cycle("sc_boot", sent + SC_LATENCY, sc_cyc_q.pop_front());
        @(posedge clock);
        boot_up <= 1'b0;
    endtask

    // Request lands while the frame path is busy
    task automatic single_cycle_blocked_mid_frame();
        @(posedge clock);
        mode <= MODE_BYPASS;
        new_frame();
        build_expected(MODE_BYPASS);
        fork
            send_frame(FRAME_WORDS, 0);
            begin
                repeat (3) @(posedge clock);
                sc_data  <= {$urandom, $urandom};
                sc_valid <= 1'b1;
                @(posedge clock);
                sc_valid <= 1'b0;
            end
        join
        collect_frame("sc_blocked", FRAME_WORDS);
        repeat (SETTLE_CYCLES) @(posedge clock);
        if (sc_q.size() != 0)
        begin
            other_errors++;
            $display("sc_blocked: a request made mid-frame returned a result");
        end
    endtask

    initial
    begin
        int unsigned seed_draw;
        seed_draw = $urandom(29760);
        reset     = 1'b1;
        beat_in   = '0;
        mode      = MODE_BYPASS;
        key       = {$urandom, $urandom};
        iv        = iv_t'({$urandom, $urandom});
        boot_up   = 1'b0;
        sc_data   = '0;
        sc_valid  = 1'b0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;

        bypass_passes_through();
        encrypt_then_decrypt();
        auth_only_tags_frame();
        resync_drops_old_frame();
        single_cycle_during_boot();
        single_cycle_blocked_mid_frame();

        $display("Checks done: %0d wrong values, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
